//--- cpu_ctrl.f
+incdir+.
cpu_ctrl_pkg.sv
instr_sequencer.sv
exec_unit.sv
cpu_ctrl.sv
cpu_ctrl_tb.sv

//--- Bender.yml
package:
  name: cpu_ctrl

sources:
  - cpu_ctrl_pkg.sv
  - instr_sequencer.sv
  - exec_unit.sv
  - cpu_ctrl.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - cpu_ctrl_tb.sv

//--- cpu_ctrl_tb_model.svh
//////////////////////////////////////////////////
// Expected controller behavior per cycle of an instruction
//////////////////////////////////////////////////

function automatic logic is_legal(input logic [6:0] op);
    return (op == cpu_ctrl_pkg::OP_R)      || (op == cpu_ctrl_pkg::OP_IMM)  ||
           (op == cpu_ctrl_pkg::OP_LOAD)   || (op == cpu_ctrl_pkg::OP_STORE) ||
           (op == cpu_ctrl_pkg::OP_BRANCH) || (op == cpu_ctrl_pkg::OP_JAL)  ||
           (op == cpu_ctrl_pkg::OP_JALR);
endfunction

// Byte, half and word follow func3[1:0]; func3[2] marks an unsigned load
function automatic cpu_ctrl_pkg::mem_size_t access_width(input logic [6:0] op,
                                                        input logic [2:0] f3);
    logic ok;
    ok = ((op == cpu_ctrl_pkg::OP_LOAD)  && (f3[1:0] != 2'd3) && !(f3[2] && f3[1])) ||
         ((op == cpu_ctrl_pkg::OP_STORE) && (f3 < 3'd3));
    if (ok)
        return cpu_ctrl_pkg::mem_size_t'(f3[1:0] + 2'd1);
    return cpu_ctrl_pkg::MEM_NONE;
endfunction

// Cycle of instr_done counted from the ir_en cycle
function automatic int retire_offset(input logic [6:0] op);
    if (!is_legal(op))
        return 4;
    return (op == cpu_ctrl_pkg::OP_LOAD) ? 7 : 6;
endfunction

function automatic cpu_ctrl_pkg::ctrl_t expected_ctrl(input logic [6:0] op,
                                                     input logic [2:0] f3,
                                                     input logic cmp, input int cycle);
    cpu_ctrl_pkg::ctrl_t     c;
    cpu_ctrl_pkg::mem_size_t w;
    logic                    load;
    c    = '0;
    w    = access_width(op, f3);
    load = (op == cpu_ctrl_pkg::OP_LOAD);
    if (cycle == 0)
        c.ir_en = 1'b1;
    else if (cycle == 1)
        c.pc_en = 1'b1;                     // The sequential step leaves pc_select at PC_SEQ
    else if (is_legal(op) && (cycle == 3 || cycle == 4 || (load && cycle == 5)))
    begin
        c.alu_src   = (op != cpu_ctrl_pkg::OP_R) && (op != cpu_ctrl_pkg::OP_JAL) &&
                      (op != cpu_ctrl_pkg::OP_BRANCH);
        c.mem_size  = w;
        if (load)
            c.wb_select = cpu_ctrl_pkg::WB_MEM;
        if (op == cpu_ctrl_pkg::OP_JAL || op == cpu_ctrl_pkg::OP_JALR)
            c.wb_select = cpu_ctrl_pkg::WB_LINK;
        if (cycle == 4)
        begin
            c.reg_write = (op == cpu_ctrl_pkg::OP_R) || (op == cpu_ctrl_pkg::OP_IMM) ||
                          (op == cpu_ctrl_pkg::OP_JAL) || (op == cpu_ctrl_pkg::OP_JALR);
            c.mem_read  = load && (w != cpu_ctrl_pkg::MEM_NONE);
            c.mem_write = (op == cpu_ctrl_pkg::OP_STORE) && (w != cpu_ctrl_pkg::MEM_NONE);
            if (op == cpu_ctrl_pkg::OP_BRANCH && cmp)
            begin
                c.pc_en     = 1'b1;
                c.pc_select = cpu_ctrl_pkg::PC_BRANCH;
            end
            if (op == cpu_ctrl_pkg::OP_JAL || op == cpu_ctrl_pkg::OP_JALR)
            begin
                c.pc_en     = 1'b1;
                c.pc_select = (op == cpu_ctrl_pkg::OP_JAL) ? cpu_ctrl_pkg::PC_JAL
                                                           : cpu_ctrl_pkg::PC_JALR;
            end
        end
        if (cycle == 5)
            c.reg_write = (w != cpu_ctrl_pkg::MEM_NONE);   // Load writeback
    end
    return c;
endfunction

//--- cpu_ctrl_tb.sv
`timescale 1ns/10ps

module cpu_ctrl_tb;

    localparam int NUM_INSTR      = 300;
    localparam int TIMEOUT_CYCLES = 16 + NUM_INSTR * 12 + 400;

    logic                              clk;
    logic                              reset;
    logic                              go;
    logic [6:0]                        opcode;
    logic [cpu_ctrl_pkg::FUNCT3_W-1:0] func3;
    logic                              comparator;
    cpu_ctrl_pkg::ctrl_t               ctrl;
    logic                              instr_done;
    logic                              illegal;

    logic [31:0] rng_state;
    int          cycle_count;
    int          offset;      // Cycles since ir_en or -1 while idle
    logic        go_prev;     // go as the DUT sees it at the next edge

    `include "cpu_ctrl_tb_model.svh"

    cpu_ctrl UUT
    (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .opcode     (opcode),
        .func3      (func3),
        .comparator (comparator),
        .ctrl       (ctrl),
        .instr_done (instr_done),
        .illegal    (illegal)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v         = rng_state;
    endtask

    function automatic logic [6:0] pick_opcode(input logic [2:0] sel);
        case (sel)
            3'd0:    return cpu_ctrl_pkg::OP_R;
            3'd1:    return cpu_ctrl_pkg::OP_IMM;
            3'd2:    return cpu_ctrl_pkg::OP_LOAD;
            3'd3:    return cpu_ctrl_pkg::OP_STORE;
            3'd4:    return cpu_ctrl_pkg::OP_BRANCH;
            3'd5:    return cpu_ctrl_pkg::OP_JAL;
            default: return cpu_ctrl_pkg::OP_JALR;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic wait_for_ir_en();
        do
            @(negedge clk);
        while (!ctrl.ir_en);
    endtask

    task automatic wait_for_done();
        do
            @(negedge clk);
        while (!instr_done);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial
    begin
        logic [31:0] r;
        int          gap;
        int          n;
        clk         = 1'b0;
        reset       = 1'b1;
        go          = 1'b0;
        opcode      = '0;
        func3       = '0;
        comparator  = 1'b0;
        rng_state   = 32'd87;
        cycle_count = 0;
        offset      = -1;
        go_prev     = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (n = 0; n < NUM_INSTR; n++)
        begin
            next_random(r);
            if (r[2:0] == 3'd7)
                opcode <= r[14:8];          // Mostly unknown opcodes
            else
                opcode <= pick_opcode(r[2:0]);
            func3      <= r[18:16];
            comparator <= r[20];
            go         <= 1'b1;
            gap = (r[26:24] == 3'd0) ? 1 + r[30:28] : 0;
            wait_for_ir_en();
            @(posedge clk);
            if (gap > 0)
                go <= 1'b0;                 // go only matters in IDLE
            wait_for_done();
            @(posedge clk);
            repeat (gap) @(posedge clk);
        end
        $display("=== PASS ===");
        $finish;
    end

    //////////////////////////////////////////////////
    // Checks on the falling edge where outputs are stable
    //////////////////////////////////////////////////

    always @(negedge clk)
    begin
        cpu_ctrl_pkg::ctrl_t exp_ctrl;
        logic                exp_done;
        logic                exp_illegal;
        exp_ctrl    = '0;
        exp_done    = 1'b0;
        exp_illegal = 1'b0;
        if (reset)
            offset = -1;
        else
        begin
            if (offset < 0 && go_prev)
                offset = 0;                 // Fetch starts this cycle
            if (offset >= 0)
            begin
                exp_ctrl    = expected_ctrl(opcode, func3, comparator, offset);
                exp_done    = (offset == retire_offset(opcode));
                exp_illegal = exp_done && !is_legal(opcode);
            end
        end
        assert (ctrl === exp_ctrl)
        else
            abort_run($sformatf("FAIL ctrl expected %h actual %h", exp_ctrl, ctrl));
        assert (instr_done === exp_done)
        else
            abort_run($sformatf("FAIL instr_done expected %h actual %h", exp_done, instr_done));
        assert (illegal === exp_illegal)
        else
            abort_run($sformatf("FAIL illegal expected %h actual %h", exp_illegal, illegal));
        if (exp_done)
            offset = -1;
        else if (offset >= 0)
            offset = offset + 1;
        go_prev = go;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("Timeout, the instructions did not all retire within the cycle limit");
    end

endmodule

//--- cpu_ctrl.sv
`timescale 1ns/10ps

module cpu_ctrl
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              go,
    input  logic [6:0]                        opcode,
    input  logic [cpu_ctrl_pkg::FUNCT3_W-1:0] func3,
    input  logic                              comparator,
    output cpu_ctrl_pkg::ctrl_t               ctrl,
    output logic                              instr_done,
    output logic                              illegal
);

    cpu_ctrl_pkg::exec_req_t exec_req;
    cpu_ctrl_pkg::ctrl_t     seq_ctrl;
    cpu_ctrl_pkg::ctrl_t     exec_ctrl;
    logic                    exec_done;

    instr_sequencer u_seq
    (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .opcode     (opcode),
        .func3      (func3),
        .comparator (comparator),
        .exec_done  (exec_done),
        .exec_req   (exec_req),
        .seq_ctrl   (seq_ctrl),
        .instr_done (instr_done),
        .illegal    (illegal)
    );

    exec_unit u_exec
    (
        .clk       (clk),
        .reset     (reset),
        .exec_req  (exec_req),
        .exec_ctrl (exec_ctrl),
        .exec_done (exec_done)
    );

    // The two units never drive strobes in the same cycle
    always_comb
    begin
        ctrl.ir_en     = seq_ctrl.ir_en | exec_ctrl.ir_en;
        ctrl.pc_en     = seq_ctrl.pc_en | exec_ctrl.pc_en;
        if (seq_ctrl.pc_en)
            ctrl.pc_select = seq_ctrl.pc_select;
        else if (exec_ctrl.pc_en)
            ctrl.pc_select = exec_ctrl.pc_select;   // Branch or jump target
        else
            ctrl.pc_select = cpu_ctrl_pkg::PC_SEQ;
        ctrl.alu_src   = seq_ctrl.alu_src | exec_ctrl.alu_src;
        ctrl.reg_write = seq_ctrl.reg_write | exec_ctrl.reg_write;
        ctrl.wb_select = exec_ctrl.wb_select;
        ctrl.mem_size  = exec_ctrl.mem_size;
        ctrl.mem_read  = seq_ctrl.mem_read | exec_ctrl.mem_read;
        ctrl.mem_write = seq_ctrl.mem_write | exec_ctrl.mem_write;
    end

endmodule

//--- exec_unit.sv
`timescale 1ns/10ps

module exec_unit
(
    input  logic                    clk,
    input  logic                    reset,
    input  cpu_ctrl_pkg::exec_req_t exec_req,
    output cpu_ctrl_pkg::ctrl_t     exec_ctrl,
    output logic                    exec_done
);

    cpu_ctrl_pkg::exec_state_t state;
    cpu_ctrl_pkg::exec_state_t state_nxt;
    cpu_ctrl_pkg::op_class_t   cls_q;
    cpu_ctrl_pkg::mem_size_t   size_q;
    logic                      taken_q;
    cpu_ctrl_pkg::op_class_t   cur_cls;
    cpu_ctrl_pkg::mem_size_t   cur_size;
    logic                      cur_taken;
    logic                      size_ok;
    logic                      in_window;   // SETUP through last action
    cpu_ctrl_pkg::ctrl_t       ctrl_nxt;

    //////////////////////////////////////////////////
    // Request latch
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (state == cpu_ctrl_pkg::EX_IDLE && exec_req.valid)
        begin
            cls_q   <= exec_req.cls;
            size_q  <= exec_req.size;
            taken_q <= exec_req.taken;
        end
    end

    // SETUP outputs are formed while the request is still on the bus
    always_comb
    begin
        if (state == cpu_ctrl_pkg::EX_IDLE)
        begin
            cur_cls   = exec_req.cls;
            cur_size  = exec_req.size;
            cur_taken = exec_req.taken;
        end
        else
        begin
            cur_cls   = cls_q;
            cur_size  = size_q;
            cur_taken = taken_q;
        end
    end

    assign size_ok = (cur_size != cpu_ctrl_pkg::MEM_NONE);

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        case (state)
            cpu_ctrl_pkg::EX_IDLE:
            begin
                if (exec_req.valid)
                    state_nxt = cpu_ctrl_pkg::EX_SETUP;
            end
            cpu_ctrl_pkg::EX_SETUP:
                state_nxt = cpu_ctrl_pkg::EX_ACT1;
            cpu_ctrl_pkg::EX_ACT1:
            begin
                // Load is the only class with a second action
                if (cur_cls == cpu_ctrl_pkg::CLS_LOAD)
                    state_nxt = cpu_ctrl_pkg::EX_ACT2;
                else
                    state_nxt = cpu_ctrl_pkg::EX_DONE;
            end
            cpu_ctrl_pkg::EX_ACT2:
                state_nxt = cpu_ctrl_pkg::EX_DONE;
            cpu_ctrl_pkg::EX_DONE:
                state_nxt = cpu_ctrl_pkg::EX_IDLE;
            default:
                state_nxt = cpu_ctrl_pkg::EX_IDLE;
        endcase
    end

    assign in_window = (state_nxt == cpu_ctrl_pkg::EX_SETUP) ||
                       (state_nxt == cpu_ctrl_pkg::EX_ACT1)  ||
                       (state_nxt == cpu_ctrl_pkg::EX_ACT2);

    //////////////////////////////////////////////////
    // Control pattern for the coming cycle
    //////////////////////////////////////////////////

    always_comb
    begin
        ctrl_nxt = cpu_ctrl_pkg::CTRL_IDLE;

        // Selects stay put for the whole microsequence
        if (in_window)
        begin
            case (cur_cls)
                cpu_ctrl_pkg::CLS_R:
                    ctrl_nxt.alu_src = 1'b0;   // rs2 operand
                cpu_ctrl_pkg::CLS_I:
                    ctrl_nxt.alu_src = 1'b1;
                cpu_ctrl_pkg::CLS_LOAD:
                begin
                    ctrl_nxt.alu_src   = 1'b1;   // Base plus offset
                    ctrl_nxt.wb_select = cpu_ctrl_pkg::WB_MEM;
                    ctrl_nxt.mem_size  = cur_size;
                end
                cpu_ctrl_pkg::CLS_STORE:
                begin
                    ctrl_nxt.alu_src  = 1'b1;
                    ctrl_nxt.mem_size = cur_size;
                end
                cpu_ctrl_pkg::CLS_JAL:
                    ctrl_nxt.wb_select = cpu_ctrl_pkg::WB_LINK;
                cpu_ctrl_pkg::CLS_JALR:
                begin
                    ctrl_nxt.wb_select = cpu_ctrl_pkg::WB_LINK;
                    ctrl_nxt.alu_src   = 1'b1;
                end
                default: ;   // Branch target comes from its own adder
            endcase
        end

        // First action cycle
        if (state_nxt == cpu_ctrl_pkg::EX_ACT1)
        begin
            case (cur_cls)
                cpu_ctrl_pkg::CLS_R,
                cpu_ctrl_pkg::CLS_I:
                    ctrl_nxt.reg_write = 1'b1;
                cpu_ctrl_pkg::CLS_LOAD:
                    ctrl_nxt.mem_read = size_ok;
                cpu_ctrl_pkg::CLS_STORE:
                    ctrl_nxt.mem_write = size_ok;
                cpu_ctrl_pkg::CLS_BRANCH:
                begin
                    if (cur_taken)
                    begin
                        ctrl_nxt.pc_en     = 1'b1;
                        ctrl_nxt.pc_select = cpu_ctrl_pkg::PC_BRANCH;
                    end
                end
                cpu_ctrl_pkg::CLS_JAL:
                begin
                    ctrl_nxt.reg_write = 1'b1;
                    ctrl_nxt.pc_en     = 1'b1;
                    ctrl_nxt.pc_select = cpu_ctrl_pkg::PC_JAL;
                end
                cpu_ctrl_pkg::CLS_JALR:
                begin
                    ctrl_nxt.reg_write = 1'b1;
                    ctrl_nxt.pc_en     = 1'b1;
                    ctrl_nxt.pc_select = cpu_ctrl_pkg::PC_JALR;
                end
                default: ;
            endcase
        end

        // Load writeback is skipped for a bad width
        if (state_nxt == cpu_ctrl_pkg::EX_ACT2)
            ctrl_nxt.reg_write = size_ok;
    end

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= cpu_ctrl_pkg::EX_IDLE;
            exec_ctrl <= cpu_ctrl_pkg::CTRL_IDLE;
            exec_done <= 1'b0;
        end
        else
        begin
            state     <= state_nxt;
            exec_ctrl <= ctrl_nxt;
            exec_done <= (state_nxt == cpu_ctrl_pkg::EX_DONE);  // Cycle after last action
        end
    end

endmodule

//--- instr_sequencer.sv
`timescale 1ns/10ps

module instr_sequencer
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              go,
    input  logic [6:0]                        opcode,
    input  logic [cpu_ctrl_pkg::FUNCT3_W-1:0] func3,
    input  logic                              comparator,
    input  logic                              exec_done,
    output cpu_ctrl_pkg::exec_req_t           exec_req,
    output cpu_ctrl_pkg::ctrl_t               seq_ctrl,
    output logic                              instr_done,
    output logic                              illegal
);

    cpu_ctrl_pkg::seq_state_t state;
    logic                     ir_en_q;
    logic                     pc_en_q;
    logic                     req_valid;
    cpu_ctrl_pkg::op_class_t  req_cls;
    cpu_ctrl_pkg::mem_size_t  req_size;
    logic                     req_taken;
    cpu_ctrl_pkg::op_class_t  dec_cls;
    cpu_ctrl_pkg::mem_size_t  dec_size;

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////

    always_comb
    begin
        case (opcode)
            cpu_ctrl_pkg::OP_R:      dec_cls = cpu_ctrl_pkg::CLS_R;
            cpu_ctrl_pkg::OP_IMM:    dec_cls = cpu_ctrl_pkg::CLS_I;
            cpu_ctrl_pkg::OP_LOAD:   dec_cls = cpu_ctrl_pkg::CLS_LOAD;
            cpu_ctrl_pkg::OP_STORE:  dec_cls = cpu_ctrl_pkg::CLS_STORE;
            cpu_ctrl_pkg::OP_BRANCH: dec_cls = cpu_ctrl_pkg::CLS_BRANCH;
            cpu_ctrl_pkg::OP_JAL:    dec_cls = cpu_ctrl_pkg::CLS_JAL;
            cpu_ctrl_pkg::OP_JALR:   dec_cls = cpu_ctrl_pkg::CLS_JALR;
            default:                 dec_cls = cpu_ctrl_pkg::CLS_NONE;
        endcase
    end

    // Signed and unsigned loads share an access width
    always_comb
    begin
        dec_size = cpu_ctrl_pkg::MEM_NONE;
        if (dec_cls == cpu_ctrl_pkg::CLS_LOAD)
        begin
            case (func3)
                3'd0, 3'd4: dec_size = cpu_ctrl_pkg::MEM_BYTE;  // LB, LBU
                3'd1, 3'd5: dec_size = cpu_ctrl_pkg::MEM_HALF;  // LH, LHU
                3'd2:       dec_size = cpu_ctrl_pkg::MEM_WORD;
                default:    dec_size = cpu_ctrl_pkg::MEM_NONE;
            endcase
        end
        else if (dec_cls == cpu_ctrl_pkg::CLS_STORE)
        begin
            case (func3)
                3'd0:    dec_size = cpu_ctrl_pkg::MEM_BYTE;
                3'd1:    dec_size = cpu_ctrl_pkg::MEM_HALF;
                3'd2:    dec_size = cpu_ctrl_pkg::MEM_WORD;
                default: dec_size = cpu_ctrl_pkg::MEM_NONE;
            endcase
        end
    end

    // Request payload is captured on entry to DECODE and held until the next one
    always_ff @(posedge clk)
    begin
        if (state == cpu_ctrl_pkg::SEQ_PC_STEP)
        begin
            req_cls   <= dec_cls;
            req_size  <= dec_size;
            req_taken <= comparator;
        end
    end

    //////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state      <= cpu_ctrl_pkg::SEQ_IDLE;
            ir_en_q    <= 1'b0;
            pc_en_q    <= 1'b0;
            req_valid  <= 1'b0;
            instr_done <= 1'b0;
            illegal    <= 1'b0;
        end
        else
        begin
            instr_done <= 1'b0;   // Pulses
            illegal    <= 1'b0;
            case (state)
                cpu_ctrl_pkg::SEQ_IDLE:
                begin
                    if (go)
                    begin
                        state   <= cpu_ctrl_pkg::SEQ_FETCH;
                        ir_en_q <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::SEQ_FETCH:
                begin
                    state   <= cpu_ctrl_pkg::SEQ_PC_STEP;
                    ir_en_q <= 1'b0;
                    pc_en_q <= 1'b1;  // Sequential step
                end
                cpu_ctrl_pkg::SEQ_PC_STEP:
                begin
                    state     <= cpu_ctrl_pkg::SEQ_DECODE;
                    pc_en_q   <= 1'b0;
                    req_valid <= (dec_cls != cpu_ctrl_pkg::CLS_NONE);
                end
                cpu_ctrl_pkg::SEQ_DECODE:
                begin
                    req_valid <= 1'b0;
                    // Nothing is issued for an unknown opcode
                    if (req_cls == cpu_ctrl_pkg::CLS_NONE)
                        state <= cpu_ctrl_pkg::SEQ_RETIRE;
                    else
                        state <= cpu_ctrl_pkg::SEQ_EXECUTE;
                end
                cpu_ctrl_pkg::SEQ_EXECUTE:
                begin
                    if (exec_done)
                    begin
                        state      <= cpu_ctrl_pkg::SEQ_IDLE;
                        instr_done <= 1'b1;
                    end
                end
                cpu_ctrl_pkg::SEQ_RETIRE:
                begin
                    state      <= cpu_ctrl_pkg::SEQ_IDLE;
                    instr_done <= 1'b1;
                    illegal    <= 1'b1;
                end
                default:
                    state <= cpu_ctrl_pkg::SEQ_IDLE;
            endcase
        end
    end

    assign exec_req = '{
        valid: req_valid,
        cls:   req_cls,
        size:  req_size,
        taken: req_taken
    };

    always_comb
    begin
        seq_ctrl           = cpu_ctrl_pkg::CTRL_IDLE;
        seq_ctrl.ir_en     = ir_en_q;
        seq_ctrl.pc_en     = pc_en_q;
        seq_ctrl.pc_select = cpu_ctrl_pkg::PC_SEQ;  // Only ever steps by one
    end

endmodule

//--- cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    localparam int FUNCT3_W = 3;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////

    // RV32I major opcodes handled by this controller
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [2:0] {
        CLS_R,
        CLS_I,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_NONE      // Opcode not recognized
    } op_class_t;

    //////////////////////////////////////////////////
    // Datapath selects
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD
    } mem_size_t;

    typedef enum logic [1:0] {
        PC_SEQ,       // PC + 4
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_sel_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK       // Return address
    } wb_sel_t;

    //////////////////////////////////////////////////
    // FSM states
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_PC_STEP,
        SEQ_DECODE,
        SEQ_EXECUTE,
        SEQ_RETIRE
    } seq_state_t;

    typedef enum logic [2:0] {
        EX_IDLE,
        EX_SETUP,
        EX_ACT1,
        EX_ACT2,
        EX_DONE
    } exec_state_t;

    //////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////

    // Issue from sequencer to execution unit
    typedef struct packed {
        logic      valid;     // One-cycle pulse
        op_class_t cls;
        mem_size_t size;
        logic      taken;     // Comparator at decode
    } exec_req_t;

    typedef struct packed {
        logic      ir_en;
        logic      pc_en;
        pc_sel_t   pc_select;
        logic      alu_src;   // 1 selects the immediate
        logic      reg_write;
        wb_sel_t   wb_select;
        mem_size_t mem_size;
        logic      mem_read;
        logic      mem_write;
    } ctrl_t;

    // All strobes low, selects at their rest values
    localparam ctrl_t CTRL_IDLE = '{
        ir_en:     1'b0,
        pc_en:     1'b0,
        pc_select: PC_SEQ,
        alu_src:   1'b0,
        reg_write: 1'b0,
        wb_select: WB_ALU,
        mem_size:  MEM_NONE,
        mem_read:  1'b0,
        mem_write: 1'b0
    };

endpackage
